/* Makefile */
# Verilator simulation of the memory dump subsystem
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module dump_tb -f build.f -o dump_sim
	./obj_dir/dump_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+source
source/dump_pkg.sv
source/btn_debounce.sv
source/data_mem.sv
source/baud_timer.sv
source/uart_tx.sv
source/dump_fsm.sv
source/dump_top.sv
tb/dump_props.sv
tb/dump_checker.sv
tb/dump_tb.sv

/* source/baud_timer.sv */
`default_nettype none

`include "dump_defines.svh"

module baud_timer (
	input  wire  CLK,
	input  wire  rst_n,
	input  wire  baud_en,  // High for the length of a frame
	output logic bit_tick  // One cycle at the end of each bit
);

	localparam int CW = $clog2(`BAUD_DIV);

	logic [CW-1:0] cnt;
	logic          last_cycle;

	assign last_cycle = (cnt == CW'(`BAUD_DIV - 1));

	always_ff @(posedge CLK) begin
		if (!rst_n || !baud_en)
			cnt <= '0; // Held at zero so each frame starts aligned
		else if (last_cycle)
			cnt <= '0; // Wrap into the next bit
		else
			cnt <= cnt + 1'b1;
	end

	assign bit_tick = baud_en && last_cycle;

endmodule

`default_nettype wire

/* source/btn_debounce.sv */
`default_nettype none

`include "dump_defines.svh"

module btn_debounce (
	input  wire        CLK,
	input  wire        rst_n,
	input  wire  [3:0] btn,   // Raw, asynchronous
	output logic [3:0] db_btn // Settled levels
);

	localparam int CW = $clog2(`DB_CYCLES + 1);

	logic [3:0]    sync_a;   // First synchronizer stage
	logic [3:0]    sync_b;   // Second stage, safe to use
	logic [3:0]    last;     // Level seen on the previous clock
	logic [CW-1:0] cnt [4];  // Stable cycles per button

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			sync_a <= '0;
			sync_b <= '0;
			last   <= '0;
			db_btn <= '0;
			for (int i = 0; i < 4; i++)
				cnt[i] <= '0;
		end else begin
			sync_a <= btn;
			sync_b <= sync_a;
			last   <= sync_b;
			for (int i = 0; i < 4; i++) begin
				if (sync_b[i] != last[i])
					cnt[i] <= '0; // Any change starts the count over
				else if (cnt[i] != CW'(`DB_CYCLES))
					cnt[i] <= cnt[i] + 1'b1;
				else
					db_btn[i] <= last[i]; // Held long enough, accept it
			end
		end
	end

endmodule

`default_nettype wire

/* source/data_mem.sv */
`default_nettype none

`include "dump_defines.svh"

module data_mem import dump_pkg::*; (
	input  wire                CLK,
	input  wire                rst_n,
	input  wire                wr_req,  // Four-phase request from the host
	input  wire  mem_wr_t      wr,
	output logic               wr_ack,
	input  wire  mem_rd_t      rd,      // Dump engine read port
	output logic [`WORD_W-1:0] rd_data
);

	logic [`WORD_W-1:0] mem [`MEM_DEPTH];

	// wr_ack doubles as the phase bit of the handshake
	// Low means waiting for req, high means waiting for req to drop
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ack <= 1'b0;
			for (int i = 0; i < `MEM_DEPTH; i++)
				mem[i] <= '0; // Unwritten words dump as zero
		end else begin
			if (wr_req && !wr_ack) begin
				mem[wr.addr] <= wr.data; // One write per request
				wr_ack       <= 1'b1;
			end else if (!wr_req && wr_ack) begin
				wr_ack <= 1'b0; // Return to zero phase
			end
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge CLK) begin
		if (rd.en)
			rd_data <= mem[rd.addr];
	end

endmodule

`default_nettype wire

/* source/dump_defines.svh */
`ifndef DUMP_DEFINES_SVH
`define DUMP_DEFINES_SVH

// Data memory geometry
`define MEM_DEPTH 16 // Words in the dump memory
`define ADDR_W    4  // Word address bits
`define WORD_W    32 // Bits per data word

// Button filter
`define DB_CYCLES 8  // Cycles a level must hold before it is taken

// UART bit timing
`define BAUD_DIV  8  // Clock cycles per UART bit

`endif

/* source/dump_fsm.sv */
`default_nettype none

`include "dump_defines.svh"

module dump_fsm import dump_pkg::*; (
	input  wire                CLK,
	input  wire                rst_n,
	input  wire                start_btn, // Debounced button 0
	output mem_rd_t            rd,
	input  wire  [`WORD_W-1:0] rd_data,
	output uart_byte_t         tx_byte,
	input  wire                byte_ack,
	input  wire                tx_busy,
	output logic               busy
);

	typedef enum logic [2:0] {
		IDLE,
		READ,     // Read strobe to the memory
		LOAD,     // Word arrives, capture it
		OFFER,    // Present one byte
		WAIT_ACK,
		WAIT_TX,  // Frame still on the line
		NEXT
	} state_t;

	state_t             state;
	logic               start_prev; // For the rising edge
	logic [`ADDR_W-1:0] addr;       // Word being dumped
	logic [1:0]         byte_idx;   // 0 is the least significant byte
	logic [`WORD_W-1:0] word;       // Captured memory word

	always_comb begin
		rd.en   = (state == READ);
		rd.addr = addr;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state      <= IDLE;
			start_prev <= 1'b0;
			addr       <= '0;
			byte_idx   <= '0;
			tx_byte    <= '0;
			busy       <= 1'b0;
		end else begin
			start_prev <= start_btn;
			case (state)
				IDLE: begin
					if (start_btn && !start_prev) begin // Edges only count here
						addr     <= '0;
						byte_idx <= '0;
						busy     <= 1'b1;
						state    <= READ;
					end
				end
				READ:  state <= LOAD;
				LOAD:  state <= OFFER;
				OFFER: begin
					tx_byte.valid <= 1'b1;
					tx_byte.data  <= word[{byte_idx, 3'b000} +: 8];
					state         <= WAIT_ACK;
				end
				WAIT_ACK: begin
					if (byte_ack) begin
						tx_byte.valid <= 1'b0; // Transmitter has the byte
						state         <= WAIT_TX;
					end
				end
				WAIT_TX: begin
					if (!tx_busy && !byte_ack) // Back-pressure from the UART
						state <= NEXT;
				end
				NEXT: begin
					if (byte_idx != 2'd3) begin
						byte_idx <= byte_idx + 1'b1;
						state    <= OFFER; // Same word, next byte
					end else if (addr == `ADDR_W'(`MEM_DEPTH - 1)) begin
						byte_idx <= '0;
						busy     <= 1'b0; // Last stop bit is out
						state    <= IDLE;
					end else begin
						byte_idx <= '0;
						addr     <= addr + 1'b1;
						state    <= READ;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Word capture, rd_data is valid during LOAD
	always_ff @(posedge CLK) begin
		if (state == LOAD)
			word <= rd_data;
	end

endmodule

`default_nettype wire

/* source/dump_pkg.sv */
`default_nettype none

`include "dump_defines.svh"

package dump_pkg;

	// Host write request, held stable while wr_req is high
	typedef struct packed {
		logic [`ADDR_W-1:0] addr; // Word address
		logic [`WORD_W-1:0] data; // Word to store
	} mem_wr_t;

	// Read request from the dump engine
	typedef struct packed {
		logic               en;   // Read strobe
		logic [`ADDR_W-1:0] addr; // Word address
	} mem_rd_t;

	// One byte offered to the UART transmitter
	typedef struct packed {
		logic       valid; // Held until byte_ack
		logic [7:0] data;  // Payload byte
	} uart_byte_t;

endpackage

`default_nettype wire

/* source/dump_top.sv */
`default_nettype none

`include "dump_defines.svh"

module dump_top import dump_pkg::*; (
	input  wire        CLK,      // Already divided board clock
	input  wire        rst_n,
	input  wire  [3:0] btn,
	input  wire  [2:0] switches,
	input  wire        wr_req,   // Host write handshake
	input  wire  mem_wr_t wr,
	output logic       wr_ack,
	output logic       tx,       // UART line out
	output logic       busy,     // Dump in progress
	output logic       irq
);

	logic [3:0]         db_btn;
	mem_rd_t            rd;
	logic [`WORD_W-1:0] rd_data;
	uart_byte_t         tx_byte;
	logic               byte_ack;
	logic               tx_busy;
	logic               baud_en;
	logic               bit_tick;

	btn_debounce debounce (
		.CLK    (CLK),
		.rst_n  (rst_n),
		.btn    (btn),
		.db_btn (db_btn)
	);

	data_mem mem (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.wr_req  (wr_req),
		.wr      (wr),
		.wr_ack  (wr_ack),
		.rd      (rd),
		.rd_data (rd_data)
	);

	// Button 0 starts the dump
	dump_fsm engine (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.start_btn (db_btn[0]),
		.rd        (rd),
		.rd_data   (rd_data),
		.tx_byte   (tx_byte),
		.byte_ack  (byte_ack),
		.tx_busy   (tx_busy),
		.busy      (busy)
	);

	uart_tx uart (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.tx_byte  (tx_byte),
		.byte_ack (byte_ack),
		.tx_busy  (tx_busy),
		.baud_en  (baud_en),
		.bit_tick (bit_tick),
		.tx       (tx)
	);

	baud_timer baud (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.baud_en  (baud_en),
		.bit_tick (bit_tick)
	);

	// Interrupt on any settled button or any switch
	always_ff @(posedge CLK) begin
		if (!rst_n)
			irq <= 1'b0;
		else
			irq <= |db_btn || |switches;
	end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`default_nettype none

module uart_tx import dump_pkg::*; (
	input  wire        CLK,
	input  wire        rst_n,
	input  wire uart_byte_t tx_byte, // Offered byte, valid held until ack
	output logic       byte_ack,
	output logic       tx_busy,  // High while a frame is on the line
	output logic       baud_en,
	input  wire        bit_tick,
	output logic       tx        // Serial line, idles high
);

	logic [9:0] frame;   // Stop, data MSB..LSB, start
	logic [3:0] bit_cnt; // Bits already sent

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			frame    <= '1; // All ones keeps the line idle
			bit_cnt  <= '0;
			byte_ack <= 1'b0;
			tx_busy  <= 1'b0;
		end else begin
			if (tx_byte.valid && !byte_ack && !tx_busy) begin
				frame    <= {1'b1, tx_byte.data, 1'b0}; // 8N1 framing
				bit_cnt  <= '0;
				byte_ack <= 1'b1;
				tx_busy  <= 1'b1;
			end else begin
				if (!tx_byte.valid)
					byte_ack <= 1'b0; // Requester has let go
				if (tx_busy && bit_tick) begin
					frame <= {1'b1, frame[9:1]}; // Next bit, fill with idle
					if (bit_cnt == 4'd9) begin
						tx_busy <= 1'b0; // Stop bit done
						bit_cnt <= '0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
		end
	end

	assign baud_en = tx_busy;   // Timer runs only during a frame
	assign tx      = frame[0];

endmodule

`default_nettype wire

/* tb/dump_checker.sv */
`default_nettype none

`include "dump_defines.svh"

module dump_checker import dump_pkg::*; (
	input  wire          CLK,
	input  wire          rst_n,
	input  wire          wr_req,
	input  wire mem_wr_t wr,
	input  wire          wr_ack,
	input  wire          tx,
	input  wire          busy,
	input  wire          irq,
	input  wire  [1:0]   check_op,  // Which check the stimulus asks for
	input  wire  [7:0]   check_val, // Its expected value
	output int           tests,
	output int           errors
);

	localparam logic [1:0] OP_RESET = 2'd1;
	localparam logic [1:0] OP_IRQ   = 2'd2;
	localparam logic [1:0] OP_DUMP  = 2'd3;
	localparam int N_BYTES = 4 * `MEM_DEPTH; // Bytes in one full dump

	logic [`WORD_W-1:0] model [`MEM_DEPTH]; // Memory as seen from the host side
	mem_wr_t    last_wr;
	logic       ack_prev, busy_prev;
	logic       in_frame;
	logic [7:0] shift;   // Data bits with the LSB arriving first
	int         ph, bi;  // Cycle within the bit, bit within the frame
	int         idx;     // Byte position in the current dump
	int         starts, dumps, bytes;
	int         mark;    // Error count at the end of the last test

	task automatic compare(input string name, input int want, input int got);
		if (want != got) begin
			$display("Error: %s expected 0x%0h got 0x%0h", name, want, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string what);
		tests++;
		$display("test %0d %s: %s", tests, what, (errors == mark) ? "pass" : "fail");
		mark = errors;
	endtask

	// Words go out in address order with the low byte first
	task automatic take_byte(input logic [7:0] got);
		logic [`WORD_W-1:0] word;
		if (idx >= N_BYTES) begin
			$display("tx sent a byte past the end of the memory");
			errors++;
		end else begin
			word = model[`ADDR_W'(idx / 4)];
			compare($sformatf("tx byte %0d", idx), int'(word[(idx % 4) * 8 +: 8]), int'(got));
		end
		idx++;
		bytes++;
	endtask

	always @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < `MEM_DEPTH; i++)
				model[i] = '0; // Memory clears on reset
			ack_prev  = 1'b0;
			busy_prev = 1'b0;
			in_frame  = 1'b0;
			ph = 0;
			bi = 0;
			idx = 0;
			starts = 0;
			dumps = 0;
			bytes = 0;
			tests = 0;
			errors = 0;
			mark = 0;
		end else begin
			if (!ack_prev && wr_ack) begin // Ack marks the held word as taken
				compare("wr_req at wr_ack rise", 1, int'(wr_req));
				model[wr.addr] = wr.data;
				last_wr = wr;
			end
			if (ack_prev && !wr_ack) begin
				compare("wr_req at wr_ack fall", 0, int'(wr_req)); // Ack drops only after req
				finish_test($sformatf("write 0x%0h <- 0x%08h", last_wr.addr, last_wr.data));
			end
			if (busy && !busy_prev) begin
				starts++;
				idx = 0;
			end
			if (!busy && busy_prev)
				dumps++;
			// UART receiver that samples each bit mid-period
			if (!in_frame) begin
				if (!tx) begin
					in_frame = 1'b1;
					ph = 0;
					bi = 0;
				end
			end else begin
				ph++;
				if (ph == `BAUD_DIV) begin
					ph = 0;
					bi++;
				end
				if (ph == `BAUD_DIV / 2) begin
					if (bi == 0 && tx) begin
						$display("tx start bit ended early, frame dropped");
						errors++;
						in_frame = 1'b0;
					end else if (bi >= 1 && bi <= 8) begin
						shift = {tx, shift[7:1]};
					end else if (bi == 9) begin
						in_frame = 1'b0;
						if (!tx) begin
							$display("tx stop bit is missing");
							errors++;
						end
						take_byte(shift);
					end
				end
			end
			case (check_op)
				OP_RESET: begin
					compare("tx", 1, int'(tx));
					compare("busy", 0, int'(busy));
					compare("wr_ack", 0, int'(wr_ack));
					compare("irq", 0, int'(irq));
					finish_test("reset state");
				end
				OP_IRQ: begin
					compare("irq", int'(check_val), int'(irq));
					finish_test("irq");
				end
				OP_DUMP: begin
					compare("busy rises", int'(check_val), starts);
					compare("busy falls", int'(check_val), dumps);
					compare("tx byte count", int'(check_val) * N_BYTES, bytes);
					if (check_val == 8'd0)
						finish_test("no dump");
					else
						finish_test("dump");
					starts = 0;
					dumps = 0;
					bytes = 0;
				end
				default: ;
			endcase
			ack_prev  = wr_ack;
			busy_prev = busy;
		end
	end

endmodule

`default_nettype wire

/* tb/dump_input.txt */
# cmd args in hex: R | W addr data | P button hold_cycles irq | S switches irq | D extra_presses
# R checks the reset state, D presses button 0 and checks one complete dump
R
W 0 11223344
W 5 deadbeef
W f 0badf00d
P 0 2 0
P 1 18 1
S 4 1
S 0 0
D 0
W 5 cafe0001
W a 80000001
D 1

/* tb/dump_props.sv */
`default_nettype none

module dump_props (
	input wire       CLK,
	input wire       rst_n,
	input wire       wr_req,
	input wire       wr_ack,
	input wire       tx,
	input wire       busy,
	input wire [3:0] db_btn // Debounced buttons inside the top
);

	// Ack only answers a pending request
	ack_follows_req: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(wr_ack) |-> $past(wr_req))
		else $error("wr_ack rose with no wr_req");

	idle_line_high: assert property (@(posedge CLK) disable iff (!rst_n)
		!busy |-> tx)
		else $error("tx left idle level while no dump ran");

	// Edge on button 0, then busy one cycle later
	busy_needs_button: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(busy) |-> $past(db_btn[0]))
		else $error("busy rose without a settled start button");

endmodule

bind dump_top dump_props props (
	.CLK(CLK), .rst_n(rst_n), .wr_req(wr_req), .wr_ack(wr_ack),
	.tx(tx), .busy(busy), .db_btn(db_btn)
);

`default_nettype wire

/* tb/dump_tb.sv */
`default_nettype none

`include "dump_defines.svh"

// Free-running testbench clock, period 4
module tb_clock (
	output logic CLK
);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

endmodule

module dump_tb import dump_pkg::*; ();

	localparam logic [1:0] OP_RESET = 2'd1;
	localparam logic [1:0] OP_IRQ   = 2'd2;
	localparam logic [1:0] OP_DUMP  = 2'd3;
	localparam int DUMP_LIMIT = 8 * `MEM_DEPTH * (10 * `BAUD_DIV + 8); // Twice a full dump

	logic            CLK;
	logic            rst_n;
	logic [3:0]      btn;
	logic [2:0]      switches;
	logic            wr_req;
	mem_wr_t         wr;
	logic            wr_ack, tx, busy, irq;
	logic [1:0]      check_op;  // One-cycle request to the checker
	logic [7:0]      check_val;
	int              n_tests, n_errors;
	bit              aborted;   // Set by a timeout or a bad stimulus line
	int              fd, n;
	logic [7:0]      cmd;
	logic [31:0]     a, b, c;
	logic [8*128-1:0] line;

	tb_clock clock (.CLK(CLK));

	dump_top DUT (
		.CLK(CLK), .rst_n(rst_n), .btn(btn), .switches(switches),
		.wr_req(wr_req), .wr(wr), .wr_ack(wr_ack), .tx(tx), .busy(busy), .irq(irq)
	);

	dump_checker check (
		.CLK(CLK), .rst_n(rst_n), .wr_req(wr_req), .wr(wr), .wr_ack(wr_ack),
		.tx(tx), .busy(busy), .irq(irq), .check_op(check_op), .check_val(check_val),
		.tests(n_tests), .errors(n_errors)
	);

	task automatic step(input int cycles);
		repeat (cycles) @(posedge CLK);
	endtask

	// Poll on the falling edge, away from the DUT updates
	task automatic await_signal(input bit on_busy, input logic level, input int limit,
			input string what);
		int t;
		t = 0;
		do begin
			@(negedge CLK);
			t++;
		end while ((on_busy ? busy : wr_ack) !== level && t < limit);
		if ((on_busy ? busy : wr_ack) !== level) begin
			$display("%s did not happen within %0d cycles", what, limit);
			aborted = 1'b1;
		end
	endtask

	task automatic ask_check(input logic [1:0] kind, input logic [7:0] value);
		@(posedge CLK);
		check_op  <= kind;
		check_val <= value;
		@(posedge CLK);
		check_op  <= 2'd0; // Pulse is one cycle
	endtask

	task automatic write_word(input logic [`ADDR_W-1:0] addr, input logic [`WORD_W-1:0] data);
		@(posedge CLK);
		wr.addr <= addr;
		wr.data <= data;
		wr_req  <= 1'b1;
		await_signal(1'b0, 1'b1, 16, "wr_ack rise");
		@(posedge CLK);
		wr_req <= 1'b0; // Return to zero
		await_signal(1'b0, 1'b0, 16, "wr_ack fall");
	endtask

	task automatic press_button(input logic [1:0] idx, input int hold, input logic [7:0] irq_val);
		@(posedge CLK);
		btn[idx] <= 1'b1;
		step(hold);
		ask_check(OP_IRQ, irq_val); // Still held here
		@(posedge CLK);
		btn[idx] <= 1'b0;
		step(2 * `DB_CYCLES + 4);   // Release settles
		ask_check(OP_DUMP, 8'd0);    // No dump may follow
	endtask

	task automatic hold_start;
		@(posedge CLK);
		btn[0] <= 1'b1;
		step(2 * `DB_CYCLES);
		@(posedge CLK);
		btn[0] <= 1'b0;
	endtask

	task automatic run_dump(input int extra);
		hold_start();
		await_signal(1'b1, 1'b1, 4 * `DB_CYCLES, "busy rise");
		for (int i = 0; i < extra && !aborted; i++) begin
			step(64);   // Well inside the dump
			hold_start();
		end
		await_signal(1'b1, 1'b0, DUMP_LIMIT, "busy fall");
		step(2 * `DB_CYCLES + 4);
		ask_check(OP_DUMP, 8'd1);
	endtask

	task automatic set_switches(input logic [2:0] value, input logic [7:0] irq_val);
		@(posedge CLK);
		switches <= value;
		step(2);    // irq is one register behind
		ask_check(OP_IRQ, irq_val);
	endtask

	task automatic bad_line(input logic [7:0] what);
		$display("stimulus line for command %c is malformed or unknown", what);
		aborted = 1'b1;
	endtask

	initial begin
		rst_n     <= 1'b0;
		btn       <= '0;
		switches  <= '0;
		wr_req    <= 1'b0;
		wr        <= '0;
		check_op  <= 2'd0;
		check_val <= 8'd0;
		aborted = 1'b0;
		step(5);
		rst_n <= 1'b1;
		fd = $fopen("tb/dump_input.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/dump_input.txt");
			aborted = 1'b1;
		end
		while (!aborted && $fscanf(fd, " %c", cmd) == 1) begin
			case (cmd)
				"#": n = $fgets(line, fd); // Rest of a comment line
				"R": ask_check(OP_RESET, 8'd0);
				"W": begin
					n = $fscanf(fd, "%h %h", a, b);
					if (n == 2)
						write_word(a[`ADDR_W-1:0], b);
					else
						bad_line(cmd);
				end
				"P": begin
					n = $fscanf(fd, "%h %h %h", a, b, c);
					if (n == 3)
						press_button(a[1:0], int'(b), c[7:0]);
					else
						bad_line(cmd);
				end
				"S": begin
					n = $fscanf(fd, "%h %h", a, b);
					if (n == 2)
						set_switches(a[2:0], b[7:0]);
					else
						bad_line(cmd);
				end
				"D": begin
					n = $fscanf(fd, "%h", a);
					if (n == 1)
						run_dump(int'(a));
					else
						bad_line(cmd);
				end
				default: bad_line(cmd);
			endcase
		end
		if (fd != 0)
			$fclose(fd);
		step(4);
		$display("tests %0d, errors %0d", n_tests, n_errors);
		if (aborted || n_errors != 0)
			$display("TEST FAILED");
		else
			$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
